// ==== hdl/videoPkg.sv ====
`default_nettype none

package videoPkg;

	// One CPU bus cycle, selects are active low
	typedef struct packed {
		logic crtcSel;
		logic ulaSel;
		logic rnw;
		logic a0;
		logic procEn;
		logic [7:0] wrData;
	} cpuBus;

	// Live raster status, enables are single-cycle pulses
	typedef struct packed {
		logic hDisp;
		logic vDisp;
		logic hSync;
		logic vSync;
		logic newLine;
		logic newScreen;
		logic charEn;
		logic fastEn;
		logic slowEn;
	} rasterState;

	// Per-character output of the CRTC
	typedef struct packed {
		logic dispEn;
		logic atCursor;
		logic [4:0] rowAddr;
		logic [13:0] frameAddr;
	} charStream;

	// Subset of 6845 register numbers
	typedef enum logic [3:0] {
		horzDisplayed = 4'd1,
		vertDisplayed = 4'd6,
		interlace = 4'd8,
		maxScanline = 4'd9,
		cursorStart = 4'd10,
		cursorEnd = 4'd11,
		startHigh = 4'd12,
		startLow = 4'd13,
		cursorHigh = 4'd14,
		cursorLow = 4'd15
	} crtcRegIndex;

	// ULA control byte, msb first
	typedef struct packed {
		logic cursorFirst;
		logic cursorSecond;
		logic cursorThird;
		logic fastCrtc;
		logic [1:0] shiftRate;
		logic teletext;
		logic flash;
	} ulaControl;

endpackage

`default_nettype wire

// ==== hdl/rasterTiming.sv ====
`timescale 1ns/1ps
`default_nettype none

module rasterTiming
	import videoPkg::*;
#(
	parameter int hDisplay = 80,
	parameter int hFront = 2,
	parameter int hPulse = 12,
	parameter int hBack = 6,
	parameter int vDisplay = 480,
	parameter int vFront = 10,
	parameter int vPulse = 2,
	parameter int vBack = 33
) (
	input wire logic PIXELCLK,
	input wire logic nRESET,
	input wire logic fastCrtc,
	output rasterState raster
);

	localparam int hWidth = $clog2(hDisplay + hFront + hPulse + hBack + 1);
	localparam int vWidth = $clog2(vDisplay + vFront + vPulse + vBack + 1);

	typedef enum logic [1:0] {phDisplay, phFront, phPulse, phBack} phaseType;

	phaseType hState, vState;
	logic [hWidth-1:0] hCount;
	logic [vWidth-1:0] vCount;
	logic [3:0] pixDiv;

	function automatic phaseType nextPhase(input phaseType ph);
		case (ph)
			phDisplay: return phFront;
			phFront: return phPulse;
			phPulse: return phBack;
			default: return phDisplay;
		endcase
	endfunction

	// Length in steps of the phase being entered
	function automatic int phaseLen(input phaseType ph, input int disp, input int front,
		input int pulse, input int back);
		case (ph)
			phDisplay: return disp;
			phFront: return front;
			phPulse: return pulse;
			default: return back;
		endcase
	endfunction

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			pixDiv <= '0;
		end else begin
			pixDiv <= pixDiv + 4'd1;
		end
	end

	// Horizontal steps per character, vertical steps per line
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			hState <= phDisplay;
			hCount <= hWidth'(hDisplay - 1);
			vState <= phDisplay;
			vCount <= vWidth'(vDisplay - 1);
		end else if (raster.charEn) begin
			if (hCount == '0) begin
				hState <= nextPhase(hState);
				hCount <= hWidth'(phaseLen(nextPhase(hState), hDisplay, hFront, hPulse, hBack) - 1);
			end else begin
				hCount <= hCount - 1'b1;
			end
			if (raster.newLine) begin
				if (vCount == '0) begin
					vState <= nextPhase(vState);
					vCount <= vWidth'(phaseLen(nextPhase(vState), vDisplay, vFront, vPulse,
						vBack) - 1);
				end else begin
					vCount <= vCount - 1'b1;
				end
			end
		end
	end

	always_comb begin
		raster.fastEn = &pixDiv[2:0];
		raster.slowEn = &pixDiv;
		raster.charEn = fastCrtc ? raster.fastEn : raster.slowEn;
		raster.hDisp = hState == phDisplay;
		raster.hSync = hState == phPulse;
		raster.vDisp = vState == phDisplay;
		raster.vSync = vState == phPulse;
		// Last character of the line, last line of the frame
		raster.newLine = hState == phBack && hCount == '0;
		raster.newScreen = raster.newLine && vState == phBack && vCount == '0;
	end

	// Counters stay inside the phase they are timing
	countInPhase: assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		hCount < phaseLen(hState, hDisplay, hFront, hPulse, hBack)
		&& vCount < phaseLen(vState, vDisplay, vFront, vPulse, vBack));

endmodule

`default_nettype wire

// ==== hdl/crtcCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module crtcCore
	import videoPkg::*;
(
	input wire logic PIXELCLK,
	input wire logic nRESET,
	input wire cpuBus bus,
	input wire rasterState raster,
	input wire logic charEn,
	output logic [7:0] rdData,
	output charStream chars
);

	crtcRegIndex regSel;
	logic [7:0] horzChars;
	logic [6:0] vertRows;
	logic [1:0] interlaceMode;
	logic [4:0] maxRow;
	logic [4:0] cursorStartRow;
	logic [4:0] cursorEndRow;
	logic [1:0] cursorBlink;
	logic [13:0] startAddr;
	logic [13:0] cursorAddr;

	logic crtcWrite;
	logic [7:0] hLeft;
	logic [6:0] vLeft;
	logic lineDouble;
	logic newVChar;
	logic field;
	logic [13:0] frameAddr;
	logic [13:0] lineAddr;
	logic [4:0] rowAddr;
	logic [6:0] blinkCount;
	logic cursorShow;

	assign crtcWrite = !bus.crtcSel && !bus.rnw && bus.procEn;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			regSel <= crtcRegIndex'(4'd0);
			horzChars <= '0;
			vertRows <= '0;
			interlaceMode <= '0;
			maxRow <= '0;
			cursorStartRow <= '0;
			cursorEndRow <= '0;
			cursorBlink <= '0;
			startAddr <= '0;
			cursorAddr <= '0;
		end else if (crtcWrite) begin
			if (!bus.a0) begin
				regSel <= crtcRegIndex'(bus.wrData[3:0]);
			end else begin
				case (regSel)
					horzDisplayed: horzChars <= bus.wrData;
					vertDisplayed: vertRows <= bus.wrData[6:0];
					interlace: interlaceMode <= bus.wrData[1:0];
					maxScanline: maxRow <= bus.wrData[4:0];
					cursorStart: begin
						cursorBlink <= bus.wrData[6:5];
						cursorStartRow <= bus.wrData[4:0];
					end
					cursorEnd: cursorEndRow <= bus.wrData[4:0];
					startHigh: startAddr[13:8] <= bus.wrData[5:0];
					startLow: startAddr[7:0] <= bus.wrData;
					cursorHigh: cursorAddr[13:8] <= bus.wrData[5:0];
					cursorLow: cursorAddr[7:0] <= bus.wrData;
					default: ;
				endcase
			end
		end
	end

	// Only the cursor address reads back
	always_comb begin
		rdData = 8'h00;
		if (!bus.crtcSel && bus.rnw) begin
			case (regSel)
				cursorHigh: rdData = {2'b00, cursorAddr[13:8]};
				cursorLow: rdData = cursorAddr[7:0];
				default: rdData = 8'h00;
			endcase
		end
	end

	// Mode 3 is true interlace and runs progressive, others repeat each scanline
	assign lineDouble = interlaceMode != 2'b11;
	assign newVChar = rowAddr == maxRow && raster.newLine && (lineDouble ? field : 1'b1);

	// Displayed-count windows
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			hLeft <= '0;
			vLeft <= '0;
		end else if (charEn) begin
			if (raster.newLine) begin
				hLeft <= horzChars;
			end else if (raster.hDisp && hLeft != '0) begin
				hLeft <= hLeft - 8'd1;
			end
			if (raster.newScreen) begin
				vLeft <= vertRows;
			end else if (newVChar && vLeft != '0) begin
				vLeft <= vLeft - 7'd1;
			end
		end
	end

	// Framestore and scanline addressing
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			frameAddr <= '0;
			lineAddr <= '0;
			rowAddr <= '0;
			field <= 1'b0;
		end else if (charEn) begin
			if (raster.newScreen) begin
				frameAddr <= startAddr;
				lineAddr <= startAddr;
			end else if (newVChar) begin
				frameAddr <= lineAddr + 14'(horzChars);
				lineAddr <= lineAddr + 14'(horzChars);
			end else if (raster.newLine) begin
				frameAddr <= lineAddr;
			end else begin
				frameAddr <= frameAddr + 14'd1;
			end
			if (raster.newScreen || newVChar) begin
				rowAddr <= '0;
				field <= 1'b0;
			end else if (raster.newLine) begin
				field <= ~field;
				rowAddr <= rowAddr + (lineDouble ? 5'(field) : 5'd1);
			end
		end
	end

	// Cursor blink, sampled once per frame
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			blinkCount <= '0;
			cursorShow <= 1'b0;
		end else if (charEn && raster.newScreen) begin
			blinkCount <= blinkCount + 7'd1;
			case (cursorBlink)
				2'b00: cursorShow <= 1'b1;
				2'b01: cursorShow <= 1'b0;
				2'b10: cursorShow <= blinkCount[5];
				default: cursorShow <= blinkCount[6];
			endcase
		end
	end

	always_comb begin
		chars.dispEn = raster.hDisp && raster.vDisp && hLeft != '0 && vLeft != '0;
		chars.frameAddr = frameAddr;
		chars.rowAddr = rowAddr;
		chars.atCursor = frameAddr == cursorAddr && rowAddr >= cursorStartRow
			&& rowAddr <= cursorEndRow && chars.dispEn && cursorShow;
	end

	rowInRange: assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		chars.dispEn |-> chars.rowAddr <= maxRow);

endmodule

`default_nettype wire

// ==== hdl/teletextGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module teletextGen
	import videoPkg::*;
(
	input wire logic PIXELCLK,
	input wire logic nRESET,
	input wire logic charEn,
	input wire logic pixelEn,
	input wire logic [7:0] vData,
	input wire rasterState raster,
	input wire charStream chars,
	output logic [2:0] colour
);

	logic [5:0] shifter;
	logic [3:0] ttxRow;
	logic oddLine;
	logic dispQ;

	// Glyphs for 0x20 to 0x27, ten rows of six dots, leftmost dot in bit 5
	function automatic logic [5:0] glyphRow(input logic [6:0] code, input logic [3:0] row);
		logic [59:0] rows;
		case (code[2:0])
			3'd1: rows = {6'h00, 6'h04, 6'h04, 6'h04, 6'h04, 6'h04, 6'h00, 6'h04, 6'h00, 6'h00};
			3'd2: rows = {6'h00, 6'h0A, 6'h0A, 6'h0A, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00};
			3'd3: rows = {6'h00, 6'h0A, 6'h0A, 6'h1F, 6'h0A, 6'h1F, 6'h0A, 6'h0A, 6'h00, 6'h00};
			3'd4: rows = {6'h00, 6'h04, 6'h0F, 6'h14, 6'h0E, 6'h05, 6'h1E, 6'h04, 6'h00, 6'h00};
			3'd5: rows = {6'h00, 6'h18, 6'h19, 6'h02, 6'h04, 6'h08, 6'h13, 6'h03, 6'h00, 6'h00};
			3'd6: rows = {6'h00, 6'h08, 6'h14, 6'h14, 6'h08, 6'h15, 6'h12, 6'h0D, 6'h00, 6'h00};
			3'd7: rows = {6'h00, 6'h04, 6'h04, 6'h08, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00, 6'h00};
			default: rows = '0;
		endcase
		if (code[6:3] != 4'h4 || row > 4'd9) begin
			return 6'h00;
		end
		return rows[59 - 6 * row -: 6];
	endfunction

	// Code looked up as it is latched, dots then leave msb first
	always_ff @(posedge PIXELCLK) begin
		if (charEn) begin
			shifter <= glyphRow(vData[6:0], ttxRow);
		end else if (pixelEn) begin
			shifter <= shifter << 1;
		end
	end

	// Teletext rows advance every second scanline
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			ttxRow <= '0;
			oddLine <= 1'b0;
			dispQ <= 1'b0;
		end else if (charEn) begin
			dispQ <= chars.dispEn;
			if (raster.newScreen) begin
				ttxRow <= '0;
				oddLine <= 1'b0;
			end else if (raster.newLine) begin
				oddLine <= ~oddLine;
				if (oddLine) begin
					ttxRow <= (ttxRow == 4'd9) ? 4'd0 : ttxRow + 4'd1;
				end
			end
		end
	end

	assign colour = (dispQ && shifter[5]) ? 3'b111 : 3'b000;

endmodule

`default_nettype wire

// ==== hdl/videoUla.sv ====
`timescale 1ns/1ps
`default_nettype none

module videoUla
	import videoPkg::*;
(
	input wire logic PIXELCLK,
	input wire logic nRESET,
	input wire cpuBus bus,
	input wire rasterState raster,
	input wire charStream chars,
	input wire logic [7:0] vData,
	input wire logic [2:0] ttxColour,
	output logic charEn,
	output logic pixelEn,
	output logic [2:0] rgb,
	output ulaControl control
);

	logic ulaWrite;
	logic [2:0] phase;
	logic [7:0] shifter;
	logic [3:0] palette [16];
	logic [3:0] palColour;
	logic [2:0] pixColour;
	logic [2:0] baseColour;
	logic bitmapDisp;
	logic [2:0] cursorSeg;
	logic cursorDraw;

	assign ulaWrite = !bus.ulaSel && !bus.rnw && bus.procEn;

	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			control <= '0;
		end else if (ulaWrite && !bus.a0) begin
			control <= ulaControl'(bus.wrData);
		end
	end

	// Upper nibble names the entry
	always_ff @(posedge PIXELCLK) begin
		if (ulaWrite && bus.a0) begin
			palette[bus.wrData[7:4]] <= bus.wrData[3:0];
		end
	end

	assign charEn = control.fastCrtc ? raster.fastEn : raster.slowEn;

	// Position within a fast character, realigned on every fastEn
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			phase <= '0;
		end else if (raster.fastEn) begin
			phase <= '0;
		end else begin
			phase <= phase + 3'd1;
		end
	end

	always_comb begin
		case (control.shiftRate)
			2'b00: pixelEn = raster.fastEn;
			2'b01: pixelEn = &phase[1:0];
			2'b10: pixelEn = phase[0];
			default: pixelEn = 1'b1;
		endcase
	end

	always_ff @(posedge PIXELCLK) begin
		if (charEn) begin
			shifter <= vData;
		end else if (pixelEn) begin
			shifter <= {shifter[6:0], 1'b1};
		end
	end

	assign palColour = palette[{shifter[7], shifter[5], shifter[3], shifter[1]}];
	// Flashing entries invert
	assign pixColour = (palColour[3] && control.flash) ? ~palColour[2:0] : palColour[2:0];

	// Window and cursor stages line up with the byte in the shifter
	always_ff @(posedge PIXELCLK) begin
		if (!nRESET) begin
			bitmapDisp <= 1'b0;
			cursorSeg <= '0;
			cursorDraw <= 1'b0;
		end else if (charEn) begin
			bitmapDisp <= chars.dispEn && chars.rowAddr < 5'd8;
			cursorSeg <= chars.atCursor ? 3'b001 : {cursorSeg[1:0], 1'b0};
			cursorDraw <= (chars.atCursor && control.cursorFirst)
				|| (cursorSeg[0] && control.cursorSecond)
				|| (cursorSeg[1] && control.cursorThird)
				|| (cursorSeg[2] && control.cursorThird);
		end
	end

	assign baseColour = control.teletext ? ttxColour : (bitmapDisp ? pixColour : 3'b000);
	assign rgb = cursorDraw ? ~baseColour : baseColour;

	// Raster block and ULA agree on the character rate
	charRateMatch: assert property (@(posedge PIXELCLK) disable iff (!nRESET)
		charEn == raster.charEn);

endmodule

`default_nettype wire

// ==== hdl/displayControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module displayControl
	import videoPkg::*;
#(
	parameter int hDisplay = 80,
	parameter int hFront = 2,
	parameter int hPulse = 12,
	parameter int hBack = 6,
	parameter int vDisplay = 480,
	parameter int vFront = 10,
	parameter int vPulse = 2,
	parameter int vBack = 33
) (
	input wire logic PIXELCLK,
	input wire logic nRESET,
	input wire cpuBus bus,
	input wire logic [7:0] vData,
	output logic [7:0] rdData,
	output logic hSync,
	output logic vSync,
	output logic dispEn,
	output logic [13:0] frameAddr,
	output logic [4:0] rowAddr,
	output logic [2:0] rgb,
	output logic txtMode
);

	rasterState raster;
	charStream chars;
	ulaControl ulaCtrl;
	logic charEn;
	logic pixelEn;
	logic [2:0] ttxColour;

	rasterTiming #(
		.hDisplay(hDisplay), .hFront(hFront), .hPulse(hPulse), .hBack(hBack),
		.vDisplay(vDisplay), .vFront(vFront), .vPulse(vPulse), .vBack(vBack)
	) u_raster (
		.PIXELCLK(PIXELCLK), .nRESET(nRESET), .fastCrtc(ulaCtrl.fastCrtc), .raster(raster)
	);

	crtcCore u_crtc (
		.PIXELCLK(PIXELCLK), .nRESET(nRESET), .bus(bus), .raster(raster),
		.charEn(charEn), .rdData(rdData), .chars(chars)
	);

	teletextGen u_ttx (
		.PIXELCLK(PIXELCLK), .nRESET(nRESET), .charEn(charEn), .pixelEn(pixelEn),
		.vData(vData), .raster(raster), .chars(chars), .colour(ttxColour)
	);

	videoUla u_ula (
		.PIXELCLK(PIXELCLK), .nRESET(nRESET), .bus(bus), .raster(raster), .chars(chars),
		.vData(vData), .ttxColour(ttxColour), .charEn(charEn), .pixelEn(pixelEn),
		.rgb(rgb), .control(ulaCtrl)
	);

	assign hSync = raster.hSync;
	assign vSync = raster.vSync;
	assign dispEn = chars.dispEn;
	assign frameAddr = chars.frameAddr;
	assign rowAddr = chars.rowAddr;
	assign txtMode = ulaCtrl.teletext;

endmodule

`default_nettype wire

// ==== sim/tbDisplayControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbDisplayControl
	import videoPkg::*;
();

	localparam int waitLimit = 4000;
	localparam int stimDepth = 128;

	logic PIXELCLK;
	logic nRESET;
	cpuBus bus;
	logic [7:0] vData;
	logic [7:0] rdData;
	logic hSync;
	logic vSync;
	logic dispEn;
	logic [13:0] frameAddr;
	logic [4:0] rowAddr;
	logic [2:0] rgb;
	logic txtMode;

	logic [31:0] stim [stimDepth];
	// Shadow copies of what was written over the bus
	logic [7:0] crtcRegs [16];
	logic [3:0] crtcIndex;
	logic [3:0] paletteModel [16];
	ulaControl ctrlModel;
	logic [13:0] rowStart [8];

	displayControl #(
		.hDisplay(4), .hFront(1), .hPulse(1), .hBack(1),
		.vDisplay(6), .vFront(1), .vPulse(1), .vBack(1)
	) u_dut (
		.PIXELCLK(PIXELCLK), .nRESET(nRESET), .bus(bus), .vData(vData), .rdData(rdData),
		.hSync(hSync), .vSync(vSync), .dispEn(dispEn), .frameAddr(frameAddr),
		.rowAddr(rowAddr), .rgb(rgb), .txtMode(txtMode)
	);

	always #20 PIXELCLK = ~PIXELCLK;

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkValue(input string label, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("[FAIL] %s expected %0h actual %0h", label, expected, actual));
		end
	endtask

	function automatic string testLabel(input logic [3:0] num);
		case (num)
			4'd1: return "regAccess";
			4'd2: return "syncPeriod";
			4'd3: return "addressing";
			4'd4: return "palette";
			4'd5: return "teletext";
			4'd6: return "cursor";
			default: return "unnamed";
		endcase
	endfunction

	// Both selects high, no processor cycle
	function automatic cpuBus idleCycle();
		cpuBus cyc;
		cyc = '0;
		cyc.crtcSel = 1'b1;
		cyc.ulaSel = 1'b1;
		cyc.rnw = 1'b1;
		return cyc;
	endfunction

	function automatic logic [2:0] paletteColour(input logic [7:0] data);
		logic [3:0] entry;
		entry = paletteModel[{data[7], data[5], data[3], data[1]}];
		return (entry[3] && ctrlModel.flash) ? ~entry[2:0] : entry[2:0];
	endfunction

	task automatic idleGap();
		int gap;
		gap = $urandom % 4;
		repeat (gap) @(posedge PIXELCLK);
	endtask

	task automatic busWrite(input logic toUla, input logic a0, input logic [7:0] data);
		cpuBus cyc;
		cyc = idleCycle();
		if (toUla) begin
			cyc.ulaSel = 1'b0;
		end else begin
			cyc.crtcSel = 1'b0;
		end
		cyc.rnw = 1'b0;
		cyc.a0 = a0;
		cyc.procEn = 1'b1;
		cyc.wrData = data;
		@(posedge PIXELCLK);
		bus <= cyc;
		@(posedge PIXELCLK);
		bus <= idleCycle();
		if (toUla && !a0) begin
			ctrlModel = ulaControl'(data);
		end else if (toUla) begin
			paletteModel[data[7:4]] = data[3:0];
		end else if (!a0) begin
			crtcIndex = data[3:0];
		end else begin
			crtcRegs[crtcIndex] = data;
		end
		idleGap();
	endtask

	task automatic crtcRead(output logic [7:0] value);
		cpuBus cyc;
		cyc = idleCycle();
		cyc.crtcSel = 1'b0;
		@(posedge PIXELCLK);
		bus <= cyc;
		@(negedge PIXELCLK);
		value = rdData;
		@(posedge PIXELCLK);
		bus <= idleCycle();
		idleGap();
	endtask

	task automatic waitVSync(input logic level, input string what);
		int guard;
		guard = 0;
		@(negedge PIXELCLK);
		while (vSync !== level) begin
			@(negedge PIXELCLK);
			guard++;
			if (guard > waitLimit) begin
				failRun({"timed out waiting for ", what});
			end
		end
	endtask

	// From one vSync rising edge to the next
	task automatic checkSync(input string label, input logic [7:0] expPulses,
		input logic [15:0] expWidth);
		int pulses;
		int width;
		int guard;
		logic lastH;
		logic seenLow;
		logic done;
		waitVSync(1'b0, "vSync low before the sync check");
		waitVSync(1'b1, "vSync rising edge that starts the sync check");
		pulses = 0;
		width = 0;
		guard = 0;
		lastH = hSync;
		seenLow = 1'b0;
		done = 1'b0;
		while (!done) begin
			@(negedge PIXELCLK);
			guard++;
			if (guard > waitLimit) begin
				failRun("vSync rising edge never came during the sync check");
			end
			if (hSync) begin
				width++;
			end
			if (hSync && !lastH) begin
				pulses++;
			end
			if (!hSync && lastH) begin
				checkValue({label, " hSync width"}, expWidth, width);
				width = 0;
			end
			lastH = hSync;
			if (!vSync) begin
				seenLow = 1'b1;
			end else if (seenLow) begin
				done = 1'b1;
			end
		end
		checkValue({label, " hSync pulses"}, expPulses, pulses);
	endtask

	// One displayed frame, checked at every character boundary
	task automatic checkFrame(input string label, input logic [7:0] expLines);
		logic [13:0] lastAddr;
		logic [13:0] prevAddr;
		logic [13:0] cursorAddr;
		logic [4:0] prevRow;
		logic [4:0] maxRow;
		logic prevDisp;
		logic drawCursor;
		logic sawWhite;
		logic [2:0] baseColour;
		logic [2:0] expColour;
		int lineIdx;
		int guard;
		maxRow = crtcRegs[maxScanline][4:0];
		cursorAddr = {crtcRegs[cursorHigh][5:0], crtcRegs[cursorLow]};
		waitVSync(1'b1, "vSync before the checked frame");
		waitVSync(1'b0, "end of vSync before the checked frame");
		checkValue({label, " txtMode"}, ctrlModel.teletext, txtMode);
		lastAddr = frameAddr;
		prevAddr = frameAddr;
		prevRow = rowAddr;
		prevDisp = dispEn;
		sawWhite = 1'b0;
		lineIdx = 0;
		guard = 0;
		while (!vSync) begin
			@(negedge PIXELCLK);
			guard++;
			if (guard > waitLimit) begin
				failRun("vSync did not return at the end of the checked frame");
			end
			if (ctrlModel.teletext && rgb === 3'b111) begin
				sawWhite = 1'b1;
			end else if (ctrlModel.teletext) begin
				checkValue({label, " black or white"}, 3'b000, rgb);
			end
			// frameAddr moves on every character enable
			if (frameAddr !== lastAddr) begin
				if (!ctrlModel.teletext) begin
					baseColour = (prevDisp && prevRow < 5'd8) ? paletteColour(vData) : 3'b000;
					drawCursor = ctrlModel.cursorFirst && crtcRegs[cursorStart][6:5] == 2'b00
						&& prevDisp && prevAddr == cursorAddr
						&& prevRow >= crtcRegs[cursorStart][4:0]
						&& prevRow <= crtcRegs[cursorEnd][4:0];
					expColour = drawCursor ? ~baseColour : baseColour;
					checkValue({label, " rgb"}, expColour, rgb);
				end
				if (dispEn && !prevDisp) begin
					checkValue({label, " rowAddr"}, lineIdx % (maxRow + 1), rowAddr);
					checkValue({label, " frameAddr"}, rowStart[(lineIdx / (maxRow + 1)) % 8],
						frameAddr);
					lineIdx++;
				end
				prevDisp = dispEn;
				prevRow = rowAddr;
				prevAddr = frameAddr;
				lastAddr = frameAddr;
			end
		end
		checkValue({label, " display lines"}, expLines, lineIdx);
		if (ctrlModel.teletext) begin
			checkValue({label, " white dots seen"}, 1'b1, sawWhite);
		end
	endtask

	task automatic runStep(input logic [31:0] word);
		logic [3:0] op;
		logic [3:0] test;
		logic [7:0] arg;
		logic [15:0] value;
		logic [7:0] readValue;
		op = word[31:28];
		test = word[27:24];
		arg = word[23:16];
		value = word[15:0];
		case (op)
			4'h1: busWrite(1'b0, arg[0], value[7:0]);
			4'h2: busWrite(1'b1, arg[0], value[7:0]);
			4'h3: begin
				crtcRead(readValue);
				checkValue(testLabel(test), value[7:0], readValue);
			end
			4'h4: begin
				@(posedge PIXELCLK);
				vData <= value[7:0];
			end
			4'h5: rowStart[arg[2:0]] = value[13:0];
			4'h6: checkSync(testLabel(test), arg, value);
			4'h7: checkFrame(testLabel(test), arg);
			default: failRun($sformatf("unknown opcode %0h in the test data", op));
		endcase
	endtask

	initial begin
		int idx;
		logic sawEnd;
		PIXELCLK = 1'b0;
		nRESET = 1'b0;
		bus = idleCycle();
		vData = 8'h00;
		void'($urandom(32'hefb4));
		for (idx = 0; idx < 16; idx++) begin
			crtcRegs[idx] = 8'h00;
			paletteModel[idx] = 4'h0;
		end
		crtcIndex = 4'h0;
		ctrlModel = '0;
		sawEnd = 1'b0;
		$readmemh("sim/testdata.txt", stim);
		repeat (4) @(posedge PIXELCLK);
		nRESET <= 1'b1;
		// Outputs idle straight out of reset
		@(negedge PIXELCLK);
		checkValue("reset hSync", 1'b0, hSync);
		checkValue("reset vSync", 1'b0, vSync);
		checkValue("reset dispEn", 1'b0, dispEn);
		checkValue("reset rgb", 3'b000, rgb);
		checkValue("reset txtMode", 1'b0, txtMode);
		for (idx = 0; idx < stimDepth; idx++) begin
			if (^stim[idx] === 1'bx) begin
				break;
			end
			if (stim[idx][31:28] == 4'hF) begin
				sawEnd = 1'b1;
				break;
			end
			runStep(stim[idx]);
		end
		if (!sawEnd) begin
			failRun("test data missing or without an end marker");
		end else begin
			$display("Testbench passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sim/testdata.txt ====
// Columns in each hex word: op[31:28] test[27:24] arg[23:16] value[15:0]
// op 1 CRTC write, 2 ULA write (arg 0 index or control, arg 1 data or palette)
// op 3 read check, 4 vData, 5 row start, 6 sync check, 7 frame check, F end
1000000E
1001002A
3100002A
1000000F
1001005C
3100005C
10000001
10010004
31000000
// Raster window, start address and cursor
10000006
10010003
10000008
10010003
10000009
10010001
1000000C
10010001
1000000D
10010020
1000000A
10010000
1000000B
10010001
1000000E
10010001
31000001
1000000F
10010025
31000025
// Syncs at slow then fast character rate
62090010
20000010
62090008
20000000
// Palette entries and expected row start addresses
200100C9
20010036
53000120
53010124
53020128
400000A5
73060000
20000001
74060000
4000005A
74060000
20000000
// Teletext
40000023
2000000A
75060000
20000000
// Cursor steady then hidden
400000A5
20000080
76060000
1000000A
10010020
76060000
F0000000

// ==== list.f ====
hdl/videoPkg.sv
hdl/rasterTiming.sv
hdl/crtcCore.sv
hdl/teletextGen.sv
hdl/videoUla.sv
hdl/displayControl.sv
sim/tbDisplayControl.sv
